// File: compile.f
+incdir+source
source/adder_tree_pkg.sv
source/skid_buffer.sv
source/fixed_adder_tree_layer.sv
source/fixed_adder_tree.sv
source/fixed_vector_mult.sv
source/fixed_dot_product.sv
sim/tb_clock_gen.sv
sim/fixed_dot_product_tb.sv

// File: Makefile
TOP := fixed_dot_product_tb

.PHONY: all lint clean

# Build and run; the exit status comes from the search for the pass message
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /Simulation finished: PASS/ { ok = 1 } END { exit !ok }'

obj_dir/V$(TOP): compile.f $(wildcard source/*.sv source/*.svh sim/*.sv)
	verilator --binary --timing -j 0 -Wno-fatal -f compile.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall -Isource \
	  source/adder_tree_pkg.sv \
	  source/skid_buffer.sv \
	  source/fixed_adder_tree_layer.sv \
	  source/fixed_adder_tree.sv \
	  source/fixed_vector_mult.sv \
	  source/fixed_dot_product.sv \
	  --top-module fixed_dot_product

clean:
	rm -rf obj_dir

// File: sim/fixed_dot_product_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "adder_tree_cfg.svh"

module fixed_dot_product_tb;

  import adder_tree_pkg::*;

  localparam int WAIT_LIMIT = 2000;
  localparam int NUM_RANDOM = 200;
  localparam logic [`ADT_IN_WIDTH-1:0] MAX_POS = {1'b0, {(`ADT_IN_WIDTH-1){1'b1}}};
  localparam logic [`ADT_IN_WIDTH-1:0] MAX_NEG = {1'b1, {(`ADT_IN_WIDTH-1){1'b0}}};

  logic        clk;
  logic        rst_n;
  dot_req_t    req;
  logic        req_valid;
  logic        req_ready;
  dot_result_t result;
  logic        result_valid;
  logic        result_ready;

  longint      exp_q[$];
  string       cur_test = "reset";
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          result_count = 0;
  int          last_result_cycle = 0;
  bit          bp_enable = 1'b0;
  bit          stall_prev = 1'b0;
  dot_result_t held_result;

  tb_clock_gen #(.PERIOD_NS(10)) u_clk (.clk(clk));

  fixed_dot_product u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  // Exact signed sum of element products
  function automatic longint expected_dot(dot_req_t r);
    longint acc;
    longint ea;
    longint eb;
    acc = 0;
    for (int i = 0; i < `ADT_VEC_SIZE; i++) begin
      ea = longint'($signed(r.a[i]));
      eb = longint'($signed(r.b[i]));
      acc += ea * eb;
    end
    return acc;
  endfunction

  function automatic dot_req_t random_req();
    dot_req_t    r;
    logic [31:0] rnd;
    for (int i = 0; i < `ADT_VEC_SIZE; i++) begin
      rnd    = $urandom();
      r.a[i] = rnd[`ADT_IN_WIDTH-1:0];
      rnd    = $urandom();
      r.b[i] = rnd[`ADT_IN_WIDTH-1:0];
    end
    return r;
  endfunction

  task automatic check_value(string name, logic signed [63:0] expected,
                             logic signed [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    errors++;
    $display("TIMEOUT in test %s: %s did not happen within %0d cycles",
             cur_test, what, WAIT_LIMIT);
    end_run();
  endtask

  task automatic finish_test(int errors_before);
    if (errors == errors_before) begin
      $display("test %-12s ok", cur_test);
    end else begin
      $display("test %-12s %0d errors", cur_test, errors - errors_before);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the transfer edge
  task automatic send_req(dot_req_t r, output int accept_cycle);
    int n;
    req       = r;
    req_valid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!req_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!req_ready) begin
      timed_out("request acceptance");
    end else begin
      accept_cycle = cycle;
      exp_q.push_back(expected_dot(r));
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_results(int target);
    int n;
    n = 0;
    while (result_count < target && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (result_count < target) begin
      timed_out("result delivery");
    end
  endtask

  always @(posedge clk) cycle <= cycle + 1;

  // Output ready pattern, random only during the back-pressure test
  always @(posedge clk) begin
    #1;
    if (bp_enable) result_ready = ($urandom() & 32'd1) != 0;
    else result_ready = 1'b1;
  end

  // Scoreboard, sampled mid cycle where valid, ready and data are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (stall_prev) begin
        check_value({cur_test, " valid held"}, 64'sd1, 64'(result_valid));
        check_value({cur_test, " result held"}, 64'(held_result), 64'(result));
      end
      stall_prev  = result_valid && !result_ready;
      held_result = result;
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR in test %s: a result arrived with no request outstanding", cur_test);
        end else begin
          check_value($sformatf("%s result %0d", cur_test, result_count),
                      exp_q.pop_front(), 64'(result));
        end
        result_count++;
        last_result_cycle = cycle;
      end
    end
  end

  initial begin
    int       acc_cycle;
    int       first_cycle;
    int       err_before;
    int       base;
    dot_req_t r;
    void'($urandom(42));
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = 1'b0;
    result_ready = 1'b1;
    err_before   = errors;

    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      check_value("reset result_valid", 64'sd0, 64'(result_valid));
    end
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value("reset req_ready", 64'sd1, 64'(req_ready));
    check_value("reset result_valid", 64'sd0, 64'(result_valid));
    finish_test(err_before);

    // Extreme operands, the last one with alternating signs
    cur_test   = "corner";
    err_before = errors;
    base       = result_count;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < `ADT_VEC_SIZE; i++) begin
        case (k)
          0: begin
            r.a[i] = MAX_NEG;
            r.b[i] = MAX_NEG;
          end
          1: begin
            r.a[i] = MAX_POS;
            r.b[i] = MAX_POS;
          end
          2: begin
            r.a[i] = MAX_POS;
            r.b[i] = MAX_NEG;
          end
          default: begin
            r.a[i] = (i % 2 == 0) ? MAX_POS : MAX_NEG;
            r.b[i] = MAX_NEG;
          end
        endcase
      end
      send_req(r, acc_cycle);
    end
    req_valid = 1'b0;
    wait_results(base + 4);
    finish_test(err_before);

    cur_test   = "latency";
    err_before = errors;
    base       = result_count;
    send_req(random_req(), acc_cycle);
    req_valid = 1'b0;
    wait_results(base + 1);
    check_value("latency cycles", 64'sd4, 64'(last_result_cycle - acc_cycle));
    finish_test(err_before);

    cur_test    = "stream";
    err_before  = errors;
    base        = result_count;
    first_cycle = 0;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      send_req(random_req(), acc_cycle);
      if (n == 0) first_cycle = acc_cycle;
    end
    req_valid = 1'b0;
    // One acceptance per cycle means no gaps between the first and last
    check_value("stream accept cycles", 64'(NUM_RANDOM - 1), 64'(acc_cycle - first_cycle));
    wait_results(base + NUM_RANDOM);
    finish_test(err_before);

    cur_test   = "backpressure";
    err_before = errors;
    base       = result_count;
    bp_enable  = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      send_req(random_req(), acc_cycle);
    end
    req_valid = 1'b0;
    wait_results(base + NUM_RANDOM);
    bp_enable = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    check_value("backpressure result count", 64'(base + NUM_RANDOM), 64'(result_count));
    finish_test(err_before);

    end_run();
  end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);

  initial clk = 1'b0;

  // Free running, first rising edge half a period in
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: source/fixed_dot_product.sv
`timescale 1ns/1ns
`default_nettype none

`include "adder_tree_cfg.svh"

// Signed dot product: multiply stage followed by the adder tree
// Latency is one multiply cycle plus one cycle per tree level
module fixed_dot_product (
  input  logic                       clk,
  input  logic                       rst_n,
  input  adder_tree_pkg::dot_req_t    req,
  input  logic                       req_valid,
  output logic                       req_ready,
  output adder_tree_pkg::dot_result_t result,
  output logic                       result_valid,
  input  logic                       result_ready
);

  import adder_tree_pkg::*;

  product_vec_t products;
  logic         products_valid;
  logic         products_ready;

  fixed_vector_mult u_mult (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .products       (products),
    .products_valid (products_valid),
    .products_ready (products_ready)
  );

  // Tree output width matches dot_result_t exactly
  fixed_adder_tree #(
    .IN_SIZE       (`ADT_VEC_SIZE),
    .IN_WIDTH      (`ADT_PROD_WIDTH)
  ) u_tree (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in       (products),
    .data_in_valid (products_valid),
    .data_in_ready (products_ready),
    .sum           (result),
    .sum_valid     (result_valid),
    .sum_ready     (result_ready)
  );

endmodule

`default_nettype wire

// File: source/fixed_vector_mult.sv
`timescale 1ns/1ns
`default_nettype none

`include "adder_tree_cfg.svh"

module fixed_vector_mult (
  input  logic                        clk,
  input  logic                        rst_n,
  input  adder_tree_pkg::dot_req_t     req,
  input  logic                        req_valid,
  output logic                        req_ready,
  output adder_tree_pkg::product_vec_t products,
  output logic                        products_valid,
  input  logic                        products_ready
);

  import adder_tree_pkg::*;

  product_vec_t products_d;

  // Full precision signed products, one per element pair
  for (genvar i = 0; i < `ADT_VEC_SIZE; i++) begin : g_mul
    logic signed [`ADT_IN_WIDTH-1:0]   a_elem;
    logic signed [`ADT_IN_WIDTH-1:0]   b_elem;
    logic signed [`ADT_PROD_WIDTH-1:0] prod;

    assign a_elem = req.a[i];
    assign b_elem = req.b[i];
    // Operands are sign extended to the product width before multiplying
    assign prod          = a_elem * b_elem;
    assign products_d[i] = prod;
  end

  skid_buffer #(
    .DATA_WIDTH     ($bits(product_vec_t))
  ) u_slice (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (products_d),
    .data_in_valid  (req_valid),
    .data_in_ready  (req_ready),
    .data_out       (products),
    .data_out_valid (products_valid),
    .data_out_ready (products_ready)
  );

endmodule

`default_nettype wire

// File: source/fixed_adder_tree.sv
`timescale 1ns/1ns
`default_nettype none

// Pipelined reduction tree, one registered layer per level
// IN_SIZE must be at least 2
module fixed_adder_tree #(
  parameter  int IN_SIZE   = 8,
  parameter  int IN_WIDTH  = 32,
  localparam int SUM_WIDTH = IN_WIDTH + $clog2(IN_SIZE)
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [IN_SIZE-1:0][IN_WIDTH-1:0] data_in,
  input  logic                             data_in_valid,
  output logic                             data_in_ready,
  output logic [SUM_WIDTH-1:0]             sum,
  output logic                             sum_valid,
  input  logic                             sum_ready
);

  localparam int LAYER_SIZE  = (IN_SIZE + 1) / 2;
  localparam int LAYER_WIDTH = IN_WIDTH + 1;

  logic [LAYER_SIZE-1:0][LAYER_WIDTH-1:0] layer_data;
  logic                                   layer_valid;
  logic                                   layer_ready;

  fixed_adder_tree_layer #(
    .IN_SIZE        (IN_SIZE),
    .IN_WIDTH       (IN_WIDTH)
  ) u_layer (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (layer_data),
    .data_out_valid (layer_valid),
    .data_out_ready (layer_ready)
  );

  if (LAYER_SIZE > 1) begin : g_next
    // More than one partial sum left, hand the rest to a smaller tree
    fixed_adder_tree #(
      .IN_SIZE       (LAYER_SIZE),
      .IN_WIDTH      (LAYER_WIDTH)
    ) u_next (
      .clk           (clk),
      .rst_n         (rst_n),
      .data_in       (layer_data),
      .data_in_valid (layer_valid),
      .data_in_ready (layer_ready),
      .sum           (sum),
      .sum_valid     (sum_valid),
      .sum_ready     (sum_ready)
    );
  end else begin : g_last
    // Last layer has a single element, which is the total
    assign sum         = layer_data;
    assign sum_valid   = layer_valid;
    assign layer_ready = sum_ready;
  end

endmodule

`default_nettype wire

// File: source/fixed_adder_tree_layer.sv
`timescale 1ns/1ns
`default_nettype none

module fixed_adder_tree_layer #(
  parameter  int IN_SIZE   = 2,
  parameter  int IN_WIDTH  = 32,
  localparam int OUT_SIZE  = (IN_SIZE + 1) / 2,
  localparam int OUT_WIDTH = IN_WIDTH + 1
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [IN_SIZE-1:0][IN_WIDTH-1:0]   data_in,
  input  logic                               data_in_valid,
  output logic                               data_in_ready,
  output logic [OUT_SIZE-1:0][OUT_WIDTH-1:0] data_out,
  output logic                               data_out_valid,
  input  logic                               data_out_ready
);

  logic [OUT_SIZE-1:0][OUT_WIDTH-1:0] pair_sum;

  // Outer elements pair up moving inward
  // e.g. with 8 inputs, out 0 is in 0 + in 7, out 3 is in 3 + in 4
  for (genvar i = 0; i < IN_SIZE / 2; i++) begin : g_pair
    logic [OUT_WIDTH-1:0] lo_ext;
    logic [OUT_WIDTH-1:0] hi_ext;

    // One guard bit per layer keeps the sum exact
    assign lo_ext      = {data_in[i][IN_WIDTH-1], data_in[i]};
    assign hi_ext      = {data_in[IN_SIZE-1-i][IN_WIDTH-1], data_in[IN_SIZE-1-i]};
    assign pair_sum[i] = lo_ext + hi_ext;
  end

  // Odd count leaves the middle element without a partner
  if (IN_SIZE % 2 != 0) begin : g_middle
    assign pair_sum[OUT_SIZE-1] = {data_in[IN_SIZE/2][IN_WIDTH-1], data_in[IN_SIZE/2]};
  end

  // Register the whole layer result in one slice
  skid_buffer #(
    .DATA_WIDTH     (OUT_SIZE * OUT_WIDTH)
  ) u_slice (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (pair_sum),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

`default_nettype wire

// File: source/skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skid_buffer #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  import adder_tree_pkg::*;

  skid_state_e           state;
  skid_state_e           state_next;
  logic [DATA_WIDTH-1:0] main_q;
  logic [DATA_WIDTH-1:0] skid_q;
  logic                  ready_q;
  logic                  in_fire;
  logic                  out_fire;
  logic                  load_main;
  logic                  load_skid;
  logic                  unpark;

  assign in_fire  = data_in_valid & ready_q;
  assign out_fire = (state != empty) & data_out_ready;

  // New item goes straight to the output register when it is free or being drained
  assign load_main = in_fire & ((state == empty) | ((state == busy) & out_fire));
  // Downstream stalled while a new item arrived, park it
  assign load_skid = in_fire & (state == busy) & ~out_fire;
  // Parked item moves forward once the output drains
  assign unpark    = (state == full) & out_fire;

  always_comb begin
    state_next = state;
    case (state)
      empty: begin
        if (in_fire) state_next = busy;
      end
      busy: begin
        if (load_skid) state_next = full;
        else if (out_fire && !in_fire) state_next = empty;
      end
      full: begin
        if (out_fire) state_next = busy;
      end
      default: state_next = empty;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= empty;
      ready_q <= 1'b1;
    end else begin
      state   <= state_next;
      // Ready is a flop, so it only drops once the skid slot is taken
      ready_q <= (state_next != full);
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) main_q <= data_in;
    else if (unpark) main_q <= skid_q;
    if (load_skid) skid_q <= data_in;
  end

  assign data_in_ready  = ready_q;
  assign data_out       = main_q;
  assign data_out_valid = (state != empty);

endmodule

`default_nettype wire

// File: source/adder_tree_pkg.sv
`default_nettype none

`include "adder_tree_cfg.svh"

package adder_tree_pkg;

  // One operand vector, element 0 in the low bits
  typedef logic [`ADT_VEC_SIZE-1:0][`ADT_IN_WIDTH-1:0] operand_vec_t;

  // A dot-product request carries both operand vectors
  typedef struct packed {
    operand_vec_t a;
    operand_vec_t b;
  } dot_req_t;

  // Full precision element-wise products
  typedef logic [`ADT_VEC_SIZE-1:0][`ADT_PROD_WIDTH-1:0] product_vec_t;

  // Exact signed sum of all products
  typedef logic signed [`ADT_SUM_WIDTH-1:0] dot_result_t;

  // Skid buffer occupancy
  // empty: nothing held
  // busy:  main register holds an item
  // full:  main and skid registers both hold an item
  typedef enum logic [1:0] {
    empty = 2'd0,
    busy  = 2'd1,
    full  = 2'd2
  } skid_state_e;

endpackage

`default_nettype wire

// File: source/adder_tree_cfg.svh
`ifndef ADT_CFG_SVH
`define ADT_CFG_SVH

// Number of elements in each operand vector
`define ADT_VEC_SIZE 8

// Signed element width of the operands
`define ADT_IN_WIDTH 16

// Exact width of one signed product
`define ADT_PROD_WIDTH (2 * `ADT_IN_WIDTH)

// Each adder tree level adds one bit, so the final sum never overflows
`define ADT_SUM_WIDTH (`ADT_PROD_WIDTH + $clog2(`ADT_VEC_SIZE))

`endif
